//--- verilog/mem_pkg.sv
package mem_pkg;

    // byte address and data widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;

    // read request, burst means a full line refill
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic              burst;
    } rd_req_t;

    // single-beat store with byte strobe
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } wr_req_t;

    // one returned read beat, resp holds the AXI code
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } rd_beat_t;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } op_t;

    // request handed from the arbiter to the bridge
    typedef struct packed {
        op_t               op;
        logic [ADDR_W-1:0] addr;
        logic              burst;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } grant_t;

endpackage

//--- verilog/axi_pkg.sv
package axi_pkg;

    // burst type and response codes
    typedef logic [1:0] burst_t;
    typedef logic [1:0] resp_t;

    localparam burst_t BURST_INCR  = 2'b01;
    localparam resp_t  RESP_OKAY   = 2'b00;
    localparam resp_t  RESP_SLVERR = 2'b10;

    // address channel, same layout for AR and AW
    typedef struct packed {
        logic [mem_pkg::ADDR_W-1:0] addr;
        logic [7:0]                 len;
        logic [2:0]                 size;
        burst_t                     burst;
    } ax_t;

    typedef ax_t ar_t;
    typedef ax_t aw_t;

    // write data beat
    typedef struct packed {
        logic [mem_pkg::DATA_W-1:0] data;
        logic [mem_pkg::STRB_W-1:0] strb;
        logic                       last;
    } w_t;

    // read data beat
    typedef struct packed {
        logic [mem_pkg::DATA_W-1:0] data;
        resp_t                      resp;
        logic                       last;
    } r_t;

    // write response
    typedef struct packed {
        resp_t resp;
    } b_t;

endpackage

//--- verilog/mem_req_arbiter.sv
`timescale 1ns/1ps

module mem_req_arbiter (
    input  logic             clock,
    input  logic             rst_n_i,
    input  mem_pkg::rd_req_t rd_req_i,
    output logic             rd_ready_o,
    input  mem_pkg::wr_req_t wr_req_i,
    output logic             wr_ready_o,
    output mem_pkg::grant_t  grant_o,
    output logic             grant_valid_o,
    input  logic             grant_ready_i,
    input  logic             done_i
);

    logic busy_q;
    // set when the last grant was a write
    logic last_wr_q;
    logic pick_wr;
    logic take;

    // write wins unless a read also waits and the write went last
    assign pick_wr = wr_req_i.valid && !(rd_req_i.valid && last_wr_q);

    // nothing new while the bridge still works on a grant
    assign grant_valid_o = !busy_q && (rd_req_i.valid || wr_req_i.valid);
    assign take          = grant_valid_o && grant_ready_i;

    // client sees ready in the same cycle the bridge takes the grant
    assign rd_ready_o = take && !pick_wr;
    assign wr_ready_o = take && pick_wr;

    always_comb begin
        grant_o.op    = pick_wr ? mem_pkg::OP_WRITE : mem_pkg::OP_READ;
        grant_o.addr  = pick_wr ? wr_req_i.addr : rd_req_i.addr;
        grant_o.burst = !pick_wr && rd_req_i.burst;
        // store payload only matters for writes
        grant_o.data  = wr_req_i.data;
        grant_o.strb  = wr_req_i.strb;
    end

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q    <= 1'b0;
            // read counts as last so a write is favored first
            last_wr_q <= 1'b0;
        end else if (take) begin
            busy_q    <= 1'b1;
            last_wr_q <= pick_wr;
        end else if (done_i) begin
            busy_q    <= 1'b0;
        end
    end

    // bridge ends only the grant it holds
    a_done_busy: assert property (@(posedge clock) disable iff (!rst_n_i)
        done_i |-> busy_q);

endmodule

//--- verilog/axi_rw_master.sv
`timescale 1ns/1ps

module axi_rw_master #(
    parameter int LINE_BEATS = 4
) (
    input  logic              clock,
    input  logic              rst_n_i,
    // granted request
    input  mem_pkg::grant_t   grant_i,
    input  logic              grant_valid_i,
    output logic              grant_ready_o,
    output logic              done_o,
    // client results
    output mem_pkg::rd_beat_t rd_beat_o,
    output logic              wr_done_o,
    output axi_pkg::resp_t    wr_resp_o,
    // read address and data
    output axi_pkg::ar_t      ar_o,
    output logic              ar_valid_o,
    input  logic              ar_ready_i,
    input  axi_pkg::r_t       r_i,
    input  logic              r_valid_i,
    output logic              r_ready_o,
    // write address, data and response
    output axi_pkg::aw_t      aw_o,
    output logic              aw_valid_o,
    input  logic              aw_ready_i,
    output axi_pkg::w_t       w_o,
    output logic              w_valid_o,
    input  logic              w_ready_i,
    input  axi_pkg::b_t       b_i,
    input  logic              b_valid_i,
    output logic              b_ready_o
);

    localparam int AW         = mem_pkg::ADDR_W;
    localparam int LINE_BYTES = LINE_BEATS * mem_pkg::STRB_W;
    // clears the offset inside a line
    localparam logic [AW-1:0] LINE_MASK = ~AW'(LINE_BYTES - 1);
    // full bus width per beat
    localparam logic [2:0] BEAT_SIZE = 3'($clog2(mem_pkg::STRB_W));
    localparam logic [7:0] BURST_LEN = 8'(LINE_BEATS - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } state_t;

    state_t       state_q;
    mem_pkg::op_t op_q;
    logic         ar_valid_q;
    logic         aw_valid_q;
    logic         w_valid_q;
    logic         done_q;
    logic         aw_open;
    logic         w_open;
    axi_pkg::ar_t ar_q;
    axi_pkg::aw_t aw_q;
    axi_pkg::w_t  w_q;

    // take a grant only when idle
    assign grant_ready_o = grant_valid_i && (state_q == ST_IDLE);
    assign done_o        = done_q;

    assign ar_o       = ar_q;
    assign ar_valid_o = ar_valid_q;
    assign aw_o       = aw_q;
    assign aw_valid_o = aw_valid_q;
    assign w_o        = w_q;
    assign w_valid_o  = w_valid_q;

    // no back-pressure on R toward the client
    assign r_ready_o = 1'b1;
    // B ready for the whole write
    assign b_ready_o = (op_q == mem_pkg::OP_WRITE) && (state_q != ST_IDLE);

    // read beats pass straight through
    always_comb begin
        rd_beat_o.valid = r_valid_i && r_ready_o;
        rd_beat_o.data  = r_i.data;
        rd_beat_o.resp  = r_i.resp;
        rd_beat_o.last  = r_i.last;
    end

    assign wr_done_o = b_valid_i && b_ready_o;
    assign wr_resp_o = b_i.resp;

    // AW and W may finish in different cycles
    assign aw_open = aw_valid_q && !aw_ready_i;
    assign w_open  = w_valid_q && !w_ready_i;

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= ST_IDLE;
            op_q       <= mem_pkg::OP_READ;
            ar_valid_q <= 1'b0;
            aw_valid_q <= 1'b0;
            w_valid_q  <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (grant_ready_o) begin
                        op_q       <= grant_i.op;
                        ar_valid_q <= (grant_i.op == mem_pkg::OP_READ);
                        // AW and W go out together
                        aw_valid_q <= (grant_i.op == mem_pkg::OP_WRITE);
                        w_valid_q  <= (grant_i.op == mem_pkg::OP_WRITE);
                        state_q    <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (op_q == mem_pkg::OP_READ) begin
                        if (ar_ready_i) begin
                            ar_valid_q <= 1'b0;
                            state_q    <= ST_DATA;
                        end
                    end else begin
                        if (aw_ready_i) begin
                            aw_valid_q <= 1'b0;
                        end
                        if (w_ready_i) begin
                            w_valid_q <= 1'b0;
                        end
                        // both accepted now or earlier
                        if (!aw_open && !w_open) begin
                            state_q <= ST_RESP;
                        end
                    end
                end
                ST_DATA: begin
                    if (r_valid_i && r_i.last) begin
                        done_q  <= 1'b1;
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    if (b_valid_i) begin
                        done_q  <= 1'b1;
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // channel payloads, loaded on accept
    always_ff @(posedge clock) begin
        if (grant_ready_o) begin
            // refill starts at the line boundary
            ar_q.addr  <= grant_i.burst ? (grant_i.addr & LINE_MASK) : grant_i.addr;
            ar_q.len   <= grant_i.burst ? BURST_LEN : 8'd0;
            ar_q.size  <= BEAT_SIZE;
            ar_q.burst <= axi_pkg::BURST_INCR;
            aw_q.addr  <= grant_i.addr;
            aw_q.len   <= 8'd0;
            aw_q.size  <= BEAT_SIZE;
            aw_q.burst <= axi_pkg::BURST_INCR;
            w_q.data   <= grant_i.data;
            w_q.strb   <= grant_i.strb;
            // single-beat writes only
            w_q.last   <= 1'b1;
        end
    end

    // AR stays up and stable until the slave takes it
    a_ar_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o));

    // slave must not return data unasked
    a_r_pending: assert property (@(posedge clock) disable iff (!rst_n_i)
        r_valid_i |-> state_q == ST_DATA);

endmodule

//--- verilog/axi_mem_slave.sv
`timescale 1ns/1ps

module axi_mem_slave #(
    parameter int MEM_WORDS  = 1024,
    parameter int LINE_BEATS = 4
) (
    input  logic         clock,
    input  logic         rst_n_i,
    input  axi_pkg::ar_t ar_i,
    input  logic         ar_valid_i,
    output logic         ar_ready_o,
    output axi_pkg::r_t  r_o,
    output logic         r_valid_o,
    input  logic         r_ready_i,
    input  axi_pkg::aw_t aw_i,
    input  logic         aw_valid_i,
    output logic         aw_ready_o,
    input  axi_pkg::w_t  w_i,
    input  logic         w_valid_i,
    output logic         w_ready_o,
    output axi_pkg::b_t  b_o,
    output logic         b_valid_o,
    input  logic         b_ready_i
);

    localparam int IDX_W  = $clog2(MEM_WORDS);
    // byte offset inside one word
    localparam int OFF_W  = $clog2(mem_pkg::STRB_W);
    localparam int WIDX_W = mem_pkg::ADDR_W - OFF_W;
    // beat counter sized for one line
    localparam int CNT_W  = $clog2(LINE_BEATS) + 1;

    logic [mem_pkg::DATA_W-1:0] mem_q [MEM_WORDS];

    // read side
    logic              ar_ready_q;
    logic              r_valid_q;
    logic              rd_incr_q;
    logic [WIDX_W-1:0] rd_idx_q;
    logic [CNT_W-1:0]  rd_cnt_q;
    logic [CNT_W-1:0]  rd_len_q;
    logic              ar_hs;
    logic              r_hs;
    logic              rd_ok;

    // write side
    logic              aw_ready_q;
    logic              w_ready_q;
    logic              aw_got_q;
    logic              w_got_q;
    logic              b_valid_q;
    axi_pkg::b_t       b_q;
    logic [WIDX_W-1:0] aw_idx_q;
    axi_pkg::w_t       w_q;
    logic              aw_hs;
    logic              w_hs;
    logic              commit;
    logic [WIDX_W-1:0] wr_idx;
    axi_pkg::w_t       wr_beat;
    logic              wr_ok;

    assign ar_ready_o = ar_ready_q;
    assign r_valid_o  = r_valid_q;
    assign aw_ready_o = aw_ready_q;
    assign w_ready_o  = w_ready_q;
    assign b_valid_o  = b_valid_q;
    assign b_o        = b_q;

    assign ar_hs = ar_valid_i && ar_ready_q;
    assign r_hs  = r_valid_q && r_ready_i;
    // each beat checked on its own, a burst may run off the end
    assign rd_ok = rd_idx_q < WIDX_W'(MEM_WORDS);

    // beat held while r_ready is low
    always_comb begin
        r_o.data = rd_ok ? mem_q[rd_idx_q[IDX_W-1:0]] : '0;
        r_o.resp = rd_ok ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
        r_o.last = (rd_cnt_q == rd_len_q);
    end

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ar_ready_q <= 1'b0;
            r_valid_q  <= 1'b0;
            rd_cnt_q   <= '0;
        end else if (ar_hs) begin
            // first beat next cycle
            ar_ready_q <= 1'b0;
            r_valid_q  <= 1'b1;
            rd_cnt_q   <= '0;
        end else if (r_hs) begin
            if (r_o.last) begin
                r_valid_q  <= 1'b0;
                ar_ready_q <= 1'b1;
            end else begin
                rd_cnt_q <= rd_cnt_q + 1'b1;
            end
        end else if (!r_valid_q) begin
            // also the rise right after reset
            ar_ready_q <= 1'b1;
        end
    end

    // burst address and length
    always_ff @(posedge clock) begin
        if (ar_hs) begin
            rd_idx_q  <= ar_i.addr[mem_pkg::ADDR_W-1:OFF_W];
            rd_len_q  <= ar_i.len[CNT_W-1:0];
            rd_incr_q <= (ar_i.burst == axi_pkg::BURST_INCR);
        end else if (r_hs && rd_incr_q) begin
            // next word
            rd_idx_q <= rd_idx_q + 1'b1;
        end
    end

    assign aw_hs = aw_valid_i && aw_ready_q;
    assign w_hs  = w_valid_i && w_ready_q;

    // use this cycle's beat if it is arriving now
    assign wr_idx  = aw_hs ? aw_i.addr[mem_pkg::ADDR_W-1:OFF_W] : aw_idx_q;
    assign wr_beat = w_hs ? w_i : w_q;
    assign wr_ok   = wr_idx < WIDX_W'(MEM_WORDS);
    // both halves present
    assign commit  = !b_valid_q && (aw_hs || aw_got_q) && (w_hs || w_got_q);

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            aw_ready_q <= 1'b0;
            w_ready_q  <= 1'b0;
            aw_got_q   <= 1'b0;
            w_got_q    <= 1'b0;
            b_valid_q  <= 1'b0;
        end else if (b_valid_q) begin
            if (b_ready_i) begin
                b_valid_q  <= 1'b0;
                aw_ready_q <= 1'b1;
                w_ready_q  <= 1'b1;
            end
        end else if (commit) begin
            // busy until B is taken
            b_valid_q  <= 1'b1;
            aw_got_q   <= 1'b0;
            w_got_q    <= 1'b0;
            aw_ready_q <= 1'b0;
            w_ready_q  <= 1'b0;
        end else begin
            if (aw_hs) begin
                aw_got_q   <= 1'b1;
                aw_ready_q <= 1'b0;
            end else if (!aw_got_q) begin
                aw_ready_q <= 1'b1;
            end
            if (w_hs) begin
                w_got_q   <= 1'b1;
                w_ready_q <= 1'b0;
            end else if (!w_got_q) begin
                w_ready_q <= 1'b1;
            end
        end
    end

    // held halves and response code
    always_ff @(posedge clock) begin
        if (aw_hs) begin
            aw_idx_q <= aw_i.addr[mem_pkg::ADDR_W-1:OFF_W];
        end
        if (w_hs) begin
            w_q <= w_i;
        end
        if (commit) begin
            b_q.resp <= wr_ok ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
        end
    end

    // only strobed bytes change, out of range is dropped
    always_ff @(posedge clock) begin
        if (commit && wr_ok) begin
            for (int i = 0; i < mem_pkg::STRB_W; i++) begin
                if (wr_beat.strb[i]) begin
                    mem_q[wr_idx[IDX_W-1:0]][8*i +: 8] <= wr_beat.data[8*i +: 8];
                end
            end
        end
    end

    // B response stays up and stable until taken
    a_b_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
        b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o));

    // master never asks for more than one line
    a_ar_len: assert property (@(posedge clock) disable iff (!rst_n_i)
        ar_valid_i |-> ar_i.len < LINE_BEATS);

endmodule

//--- verilog/rvseed_mem_top.sv
`timescale 1ns/1ps

module rvseed_mem_top #(
    parameter int MEM_WORDS  = 1024,
    parameter int LINE_BEATS = 4
) (
    input  logic              clock,
    input  logic              rst_n_i,
    input  mem_pkg::rd_req_t  rd_req_i,
    output logic              rd_ready_o,
    input  mem_pkg::wr_req_t  wr_req_i,
    output logic              wr_ready_o,
    output mem_pkg::rd_beat_t rd_beat_o,
    output logic              wr_done_o,
    output axi_pkg::resp_t    wr_resp_o
);

    // arbiter to bridge
    mem_pkg::grant_t grant;
    logic            grant_valid;
    logic            grant_ready;
    logic            done;

    // bridge to memory
    axi_pkg::ar_t ar;
    axi_pkg::r_t  r;
    axi_pkg::aw_t aw;
    axi_pkg::w_t  w;
    axi_pkg::b_t  b;
    logic         ar_valid;
    logic         ar_ready;
    logic         r_valid;
    logic         r_ready;
    logic         aw_valid;
    logic         aw_ready;
    logic         w_valid;
    logic         w_ready;
    logic         b_valid;
    logic         b_ready;

    mem_req_arbiter i_mem_req_arbiter (
        .clock         (clock),
        .rst_n_i       (rst_n_i),
        .rd_req_i      (rd_req_i),
        .rd_ready_o    (rd_ready_o),
        .wr_req_i      (wr_req_i),
        .wr_ready_o    (wr_ready_o),
        .grant_o       (grant),
        .grant_valid_o (grant_valid),
        .grant_ready_i (grant_ready),
        .done_i        (done)
    );

    axi_rw_master #(
        .LINE_BEATS (LINE_BEATS)
    ) i_axi_rw_master (
        .clock         (clock),
        .rst_n_i       (rst_n_i),
        .grant_i       (grant),
        .grant_valid_i (grant_valid),
        .grant_ready_o (grant_ready),
        .done_o        (done),
        .rd_beat_o     (rd_beat_o),
        .wr_done_o     (wr_done_o),
        .wr_resp_o     (wr_resp_o),
        .ar_o          (ar),
        .ar_valid_o    (ar_valid),
        .ar_ready_i    (ar_ready),
        .r_i           (r),
        .r_valid_i     (r_valid),
        .r_ready_o     (r_ready),
        .aw_o          (aw),
        .aw_valid_o    (aw_valid),
        .aw_ready_i    (aw_ready),
        .w_o           (w),
        .w_valid_o     (w_valid),
        .w_ready_i     (w_ready),
        .b_i           (b),
        .b_valid_i     (b_valid),
        .b_ready_o     (b_ready)
    );

    axi_mem_slave #(
        .MEM_WORDS  (MEM_WORDS),
        .LINE_BEATS (LINE_BEATS)
    ) i_axi_mem_slave (
        .clock      (clock),
        .rst_n_i    (rst_n_i),
        .ar_i       (ar),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .r_o        (r),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .aw_i       (aw),
        .aw_valid_i (aw_valid),
        .aw_ready_o (aw_ready),
        .w_i        (w),
        .w_valid_i  (w_valid),
        .w_ready_o  (w_ready),
        .b_o        (b),
        .b_valid_o  (b_valid),
        .b_ready_i  (b_ready)
    );

endmodule

//--- test/tb_rvseed_mem_top.sv
`timescale 1ns/1ps

module tb_rvseed_mem_top;

    localparam int MEM_WORDS  = 1024;
    localparam int LINE_BEATS = 4;
    localparam int AW         = mem_pkg::ADDR_W;
    localparam int DW         = mem_pkg::DATA_W;
    localparam int SW         = mem_pkg::STRB_W;
    // sizes of the test sections
    localparam int N_RAND  = 16;
    localparam int N_PART  = 12;
    localparam int N_LINES = 3;
    localparam int N_PAIRS = 8;
    localparam int N_OPS   = 2 * N_RAND + 2 * N_PART + N_LINES * (LINE_BEATS + 1)
                             + 3 * N_PAIRS + 4;

    logic              clock;
    logic              rst_n_i;
    mem_pkg::rd_req_t  rd_req;
    logic              rd_ready;
    mem_pkg::wr_req_t  wr_req;
    logic              wr_ready;
    mem_pkg::rd_beat_t rd_beat;
    logic              wr_done;
    axi_pkg::resp_t    wr_resp;

    integer seed = 74939;
    int     value_errs = 0;
    int     other_errs = 0;
    // which op the arbiter served last, reads count as last after reset
    bit     last_was_wr = 1'b0;

    // memory model
    logic [DW-1:0] shadow_mem [MEM_WORDS];
    bit            shadow_vld [MEM_WORDS];

    // expected and observed results
    mem_pkg::rd_beat_t exp_beats [$];
    mem_pkg::rd_beat_t act_beats [$];
    axi_pkg::resp_t    exp_resps [$];
    axi_pkg::resp_t    act_resps [$];

    rvseed_mem_top #(
        .MEM_WORDS  (MEM_WORDS),
        .LINE_BEATS (LINE_BEATS)
    ) i_rvseed_mem_top (
        .clock      (clock),
        .rst_n_i    (rst_n_i),
        .rd_req_i   (rd_req),
        .rd_ready_o (rd_ready),
        .wr_req_i   (wr_req),
        .wr_ready_o (wr_ready),
        .rd_beat_o  (rd_beat),
        .wr_done_o  (wr_done),
        .wr_resp_o  (wr_resp)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // bytewise store merge
    function automatic logic [DW-1:0] merge_word(input logic [DW-1:0] old_word,
                                                 input logic [DW-1:0] new_data,
                                                 input logic [SW-1:0] strb);
        logic [DW-1:0] res;
        res = old_word;
        for (int i = 0; i < SW; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_data[8*i +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [AW-1:0] addr_of(input int idx);
        return AW'(idx * SW);
    endfunction

    function automatic int rand_word();
        return int'($unsigned($random(seed)) % MEM_WORDS);
    endfunction

    function automatic logic [DW-1:0] rand_data();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic check_beat(input mem_pkg::rd_beat_t got, input mem_pkg::rd_beat_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("Fail at %0t: read beat data %h resp %0d last %0b, expected %h %0d %0b",
                     $time, got.data, got.resp, got.last, exp.data, exp.resp, exp.last);
        end
    endtask

    task automatic check_wr_resp(input axi_pkg::resp_t got, input axi_pkg::resp_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("Fail at %0t: write response %0d, expected %0d", $time, got, exp);
        end
    endtask

    // beats a read must return, in order
    task automatic expect_read(input logic [AW-1:0] addr, input logic burst);
        mem_pkg::rd_beat_t beat;
        int first;
        int count;
        int idx;
        first = int'(addr >> $clog2(SW));
        count = 1;
        if (burst) begin
            first = first - (first % LINE_BEATS);
            count = LINE_BEATS;
        end
        for (int b = 0; b < count; b++) begin
            idx        = first + b;
            beat.valid = 1'b1;
            beat.last  = (b == count - 1);
            if (idx < MEM_WORDS) begin
                if (!shadow_vld[idx]) begin
                    other_errs++;
                    $display("test reads word %0d which it never wrote", idx);
                end
                beat.data = shadow_mem[idx];
                beat.resp = axi_pkg::RESP_OKAY;
            end else begin
                beat.data = '0;
                beat.resp = axi_pkg::RESP_SLVERR;
            end
            exp_beats.push_back(beat);
        end
    endtask

    task automatic expect_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                                input logic [SW-1:0] strb);
        int idx;
        idx = int'(addr >> $clog2(SW));
        if (idx < MEM_WORDS) begin
            if (shadow_vld[idx]) begin
                shadow_mem[idx] = merge_word(shadow_mem[idx], data, strb);
            end else if (strb == '1) begin
                shadow_mem[idx] = data;
                shadow_vld[idx] = 1'b1;
            end
            exp_resps.push_back(axi_pkg::RESP_OKAY);
        end else begin
            // dropped by the slave
            exp_resps.push_back(axi_pkg::RESP_SLVERR);
        end
    endtask

    // drive one or both requests and follow them until each is accepted
    task automatic issue_reqs(input bit send_rd, input logic burst, input logic [AW-1:0] rd_addr,
                              input bit send_wr, input logic [AW-1:0] wr_addr,
                              input logic [DW-1:0] wr_data, input logic [SW-1:0] wr_strb);
        bit rd_left;
        bit wr_left;
        bit want_wr;
        rd_left = send_rd;
        wr_left = send_wr;
        @(negedge clock);
        rd_req.valid = send_rd;
        rd_req.addr  = rd_addr;
        rd_req.burst = burst;
        wr_req.valid = send_wr;
        wr_req.addr  = wr_addr;
        wr_req.data  = wr_data;
        wr_req.strb  = wr_strb;
        while (rd_left || wr_left) begin
            // ready is settled well before the next rising edge
            #1;
            // both waiting means the op not served last goes first
            want_wr = (rd_left && wr_left) ? !last_was_wr : wr_left;
            if (rd_ready || wr_ready) begin
                if (wr_ready != want_wr) begin
                    value_errs++;
                    $display("Fail at %0t: %s granted first, expected %s", $time,
                             wr_ready ? "write" : "read", want_wr ? "write" : "read");
                end
                if (wr_ready) begin
                    expect_write(wr_addr, wr_data, wr_strb);
                    wr_left     = 1'b0;
                    last_was_wr = 1'b1;
                end else begin
                    expect_read(rd_addr, burst);
                    rd_left     = 1'b0;
                    last_was_wr = 1'b0;
                end
            end
            @(negedge clock);
            rd_req.valid = rd_left;
            wr_req.valid = wr_left;
        end
    endtask

    task automatic write_word(input int idx, input logic [DW-1:0] data, input logic [SW-1:0] strb);
        issue_reqs(1'b0, 1'b0, '0, 1'b1, addr_of(idx), data, strb);
    endtask

    task automatic read_word(input int idx);
        issue_reqs(1'b1, 1'b0, addr_of(idx), 1'b0, '0, '0, '0);
    endtask

    task automatic read_line(input logic [AW-1:0] addr);
        issue_reqs(1'b1, 1'b1, addr, 1'b0, '0, '0, '0);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_beats.size() > 0 || exp_resps.size() > 0) && n < 100) begin
            @(negedge clock);
            n++;
        end
        if (exp_beats.size() > 0 || exp_resps.size() > 0) begin
            other_errs++;
            $display("%0d read beats and %0d write responses never arrived",
                     exp_beats.size(), exp_resps.size());
        end
        // room for stray responses
        repeat (10) @(negedge clock);
    endtask

    // records results where they are stable
    initial begin : collector
        forever begin
            @(negedge clock);
            if (rd_beat.valid) begin
                act_beats.push_back(rd_beat);
            end
            if (wr_done) begin
                act_resps.push_back(wr_resp);
            end
        end
    end

    initial begin : compare
        forever begin
            @(posedge clock);
            while (act_beats.size() > 0) begin
                if (exp_beats.size() == 0) begin
                    other_errs++;
                    $display("read beat arrived with no request waiting for it");
                    void'(act_beats.pop_front());
                end else begin
                    check_beat(act_beats.pop_front(), exp_beats.pop_front());
                end
            end
            while (act_resps.size() > 0) begin
                if (exp_resps.size() == 0) begin
                    other_errs++;
                    $display("write response arrived with no write waiting for it");
                    void'(act_resps.pop_front());
                end else begin
                    check_wr_resp(act_resps.pop_front(), exp_resps.pop_front());
                end
            end
        end
    end

    initial begin : watchdog
        repeat (N_OPS * 40) @(posedge clock);
        $display("timeout, the run did not finish within %0d cycles", N_OPS * 40);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        int            words [N_RAND];
        int            idx;
        int            base;
        logic [SW-1:0] strb;
        rst_n_i = 1'b0;
        rd_req  = '0;
        wr_req  = '0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        rst_n_i = 1'b1;

        // full-strobe writes, then single reads
        for (int i = 0; i < N_RAND; i++) begin
            words[i] = rand_word();
            write_word(words[i], rand_data(), '1);
        end
        for (int i = 0; i < N_RAND; i++) begin
            read_word(words[i]);
        end

        // partial strobes over written words
        for (int i = 0; i < N_PART; i++) begin
            idx  = words[i % N_RAND];
            strb = SW'($random(seed));
            write_word(idx, rand_data(), strb);
            read_word(idx);
        end

        // refill bursts, started from inside the line
        for (int i = 0; i < N_LINES; i++) begin
            base = rand_word() & ~(LINE_BEATS - 1);
            for (int b = 0; b < LINE_BEATS; b++) begin
                write_word(base + b, rand_data(), '1);
            end
            idx = base + int'($unsigned($random(seed)) % LINE_BEATS);
            read_line(addr_of(idx) + AW'($unsigned($random(seed)) % SW));
        end

        // same-cycle read and write to one word
        for (int i = 0; i < N_PAIRS; i++) begin
            idx = words[i];
            // a single op first so both orders come up
            if (i % 2 == 0) begin
                write_word(idx, rand_data(), '1);
            end else begin
                read_word(idx);
            end
            issue_reqs(1'b1, 1'b0, addr_of(idx), 1'b1, addr_of(idx), rand_data(),
                       SW'($random(seed)));
        end

        // beyond the memory, aliasing onto a known word
        idx = words[0];
        write_word(MEM_WORDS + idx, rand_data(), '1);
        read_word(MEM_WORDS + idx);
        read_word(idx);

        wait_drain();
        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- rvseed_soc.f
verilog/mem_pkg.sv
verilog/axi_pkg.sv
verilog/mem_req_arbiter.sv
verilog/axi_rw_master.sv
verilog/axi_mem_slave.sv
verilog/rvseed_mem_top.sv
test/tb_rvseed_mem_top.sv

//--- Makefile
TB_TOP  = tb_rvseed_mem_top
RTL_TOP = rvseed_mem_top

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f rvseed_soc.f \
		--top-module $(TB_TOP) -Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -Wall -f rvseed_soc.f --top-module $(RTL_TOP)

clean:
	rm -rf obj_dir sim.log
